// File: Makefile
# Verilator build and run of the organ testbench

VERILATOR ?= verilator
TOP       ?= organ_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/hex_display.sv
`timescale 1ns/1ns

module hex_display (
  input  logic                          CLK_50M,
  input  logic                          rst_n,
  input  logic                          tick_2hz,
  input  logic [organ_pkg::count_w-1:0] sample_count,
  output logic [organ_pkg::seg_w-1:0]   hex0,
  output logic [organ_pkg::seg_w-1:0]   hex1,
  output logic [organ_pkg::seg_w-1:0]   hex2,
  output logic [organ_pkg::seg_w-1:0]   hex3,
  output logic [organ_pkg::seg_w-1:0]   hex4,
  output logic [organ_pkg::seg_w-1:0]   hex5
);

  import organ_pkg::*;

  display_word_t    shown;
  logic [seg_w-1:0] seg [digit_count];

  // Refresh twice per second so digits stay readable
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      shown.count <= disp_w'(default_sample_count);
    else if (tick_2hz)
      shown.count <= {{(disp_w-count_w){1'b0}}, sample_count};
  end

  // One decoder per hex digit
  for (genvar i = 0; i < digit_count; i++)
  begin : g_seg
    assign seg[i] = seg_table[shown.digit[i]];
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];
  assign hex4 = seg[4];
  assign hex5 = seg[5];

endmodule

// File: hdl/key_repeat.sv
`timescale 1ns/1ns

module key_repeat #(
  parameter int clk_hz = 50_000_000
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [2:0] keys,
  output logic       up_pulse,
  output logic       down_pulse,
  output logic       restore
);

  import organ_pkg::*;

  localparam int repeat_period = clk_hz / repeats_per_sec;
  localparam int rep_w         = $clog2(repeat_period);

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [1:0]       key_prev;
  logic [1:0]       fire;
  logic [rep_w-1:0] rep_cnt [2];

  // Two-flop synchronizer, keys inverted to active high
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= ~keys;
      key_sync <= key_meta;
      key_prev <= key_sync[1:0];
    end
  end

  // Up and down keys repeat, restore is a plain level
  for (genvar k = 0; k < 2; k++)
  begin : g_rep
    always_ff @(posedge CLK_50M)
    begin
      if (!rst_n)
      begin
        rep_cnt[k] <= '0;
        fire[k]    <= 1'b0;
      end
      else if (key_sync[k] && !key_prev[k])
      begin
        // New press, fire now and restart the repeat timer
        rep_cnt[k] <= '0;
        fire[k]    <= 1'b1;
      end
      else if (key_sync[k] && rep_cnt[k] == rep_w'(repeat_period - 1))
      begin
        rep_cnt[k] <= '0;
        fire[k]    <= 1'b1;
      end
      else
      begin
        rep_cnt[k] <= key_sync[k] ? rep_cnt[k] + 1'b1 : '0;
        fire[k]    <= 1'b0;
      end
    end
  end

  assign up_pulse   = fire[0];
  assign down_pulse = fire[1];
  assign restore    = key_sync[2];

endmodule

// File: hdl/led_chaser.sv
`timescale 1ns/1ns

module led_chaser (
  input  logic                             CLK_50M,
  input  logic                             rst_n,
  input  logic                             tick_8hz,
  input  logic                             tick_4hz,
  input  logic                             tick_2hz,
  input  logic                             tick_1hz,
  input  logic [organ_pkg::rate_sel_w-1:0] rate_sel,
  output logic [organ_pkg::led_count-1:0]  led
);

  import organ_pkg::*;

  localparam int pos_w = $clog2(led_count);

  logic [pos_w-1:0] pos;
  logic             dir_down;
  logic             step;

  always_comb
  begin
    case (rate_sel)
      2'd0:    step = tick_1hz;
      2'd1:    step = tick_2hz;
      2'd2:    step = tick_4hz;
      default: step = tick_8hz;
    endcase
  end

  // Bounce, turning around at either end
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      pos      <= '0;
      dir_down <= 1'b0;
    end
    else if (step)
    begin
      if (dir_down)
      begin
        pos <= pos - 1'b1;
        if (pos == pos_w'(1))
          dir_down <= 1'b0;
      end
      else
      begin
        pos <= pos + 1'b1;
        if (pos == pos_w'(led_count - 2))
          dir_down <= 1'b1;
      end
    end
  end

  assign led = {{(led_count-1){1'b0}}, 1'b1} << pos;

endmodule

// File: hdl/organ_pkg.sv
package organ_pkg;

  // ==================================================
  // Audio
  // ==================================================
  localparam int sample_w   = 8;
  localparam int note_sel_w = 3;

  // Do, Re, Mi, Fa, So, La, Si, Do in Hz
  localparam logic [31:0] note_hz_table [2**note_sel_w] = '{
    32'd523, 32'd587, 32'd659, 32'd698,
    32'd783, 32'd880, 32'd987, 32'd1046
  };

  // ==================================================
  // LED chaser
  // ==================================================
  localparam int led_count  = 8;
  localparam int rate_sel_w = 2;

  // ==================================================
  // Scope sampling count and its display
  // ==================================================
  localparam int count_w = 16;
  localparam logic [count_w-1:0] default_sample_count = 16'd12499;
  localparam logic [count_w-1:0] speed_step = 16'd100;
  localparam int repeats_per_sec = 10;

  localparam int digit_count = 6;
  localparam int digit_w     = 4;
  localparam int disp_w      = digit_count * digit_w;
  localparam int seg_w       = 7;

  // Active low, segment a in bit 0 through g in bit 6
  localparam logic [seg_w-1:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

  // Same word, seen as one count or as hex digits
  typedef union packed {
    logic [disp_w-1:0]                   count;
    logic [digit_count-1:0][digit_w-1:0] digit;
  } display_word_t;

endpackage

// File: hdl/organ_top.sv
`timescale 1ns/1ns

module organ_top #(
  parameter int clk_hz = 50_000_000
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [9:0] sw,
  input  logic [3:0] keys,
  output logic [7:0] led,
  output logic [7:0] audio_sample,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3,
  output logic [6:0] hex4,
  output logic [6:0] hex5
);

  logic        tick_8hz;
  logic        tick_4hz;
  logic        tick_2hz;
  logic        tick_1hz;
  logic        up_pulse;
  logic        down_pulse;
  logic        restore;
  logic [15:0] sample_count;

  // ==================================================
  // Timing strobes
  // ==================================================
  tick_generator #(.clk_hz(clk_hz)) u_ticks (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick_8hz(tick_8hz),
    .tick_4hz(tick_4hz),
    .tick_2hz(tick_2hz),
    .tick_1hz(tick_1hz)
  );

  // SW[0] gates the tone, SW[3:1] picks the note
  tone_generator #(.clk_hz(clk_hz)) u_tone (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .sound_on    (sw[0]),
    .note_sel    (sw[3:1]),
    .audio_sample(audio_sample)
  );

  led_chaser u_leds (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick_8hz(tick_8hz),
    .tick_4hz(tick_4hz),
    .tick_2hz(tick_2hz),
    .tick_1hz(tick_1hz),
    .rate_sel(sw[5:4]),
    .led     (led)
  );

  // ==================================================
  // Scope speed control and display
  // ==================================================
  key_repeat #(.clk_hz(clk_hz)) u_keys (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .keys      (keys[2:0]),
    .up_pulse  (up_pulse),
    .down_pulse(down_pulse),
    .restore   (restore)
  );

  speed_register u_speed (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .up_pulse    (up_pulse),
    .down_pulse  (down_pulse),
    .restore     (restore),
    .sample_count(sample_count)
  );

  hex_display u_hex (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .tick_2hz    (tick_2hz),
    .sample_count(sample_count),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5)
  );

endmodule

// File: hdl/speed_register.sv
`timescale 1ns/1ns

module speed_register (
  input  logic                          CLK_50M,
  input  logic                          rst_n,
  input  logic                          up_pulse,
  input  logic                          down_pulse,
  input  logic                          restore,
  output logic [organ_pkg::count_w-1:0] sample_count
);

  import organ_pkg::*;

  logic signed [count_w-1:0] offset;

  // ==================================================
  // Offset accumulator, wraps freely
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      offset       <= '0;
      sample_count <= default_sample_count;
    end
    else
    begin
      if (restore)
        offset <= '0;
      else if (up_pulse)
        offset <= offset + $signed(speed_step);
      else if (down_pulse)
        offset <= offset - $signed(speed_step);
      sample_count <= default_sample_count + offset;
    end
  end

endmodule

// File: hdl/tick_generator.sv
`timescale 1ns/1ns

module tick_generator #(
  parameter int clk_hz = 50_000_000
) (
  input  logic CLK_50M,
  input  logic rst_n,
  output logic tick_8hz,
  output logic tick_4hz,
  output logic tick_2hz,
  output logic tick_1hz
);

  localparam int base_div = clk_hz / 8;
  localparam int base_w   = $clog2(base_div);

  logic [base_w-1:0] base_cnt;
  logic [2:0]        div_cnt;
  logic              base_wrap;

  assign base_wrap = (base_cnt == base_w'(base_div - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      base_cnt <= '0;
      div_cnt  <= '0;
      tick_8hz <= 1'b0;
      tick_4hz <= 1'b0;
      tick_2hz <= 1'b0;
      tick_1hz <= 1'b0;
    end
    else
    begin
      base_cnt <= base_wrap ? '0 : base_cnt + 1'b1;
      if (base_wrap)
        div_cnt <= div_cnt + 1'b1;
      // Slower strobes land on every second pulse of the faster one
      tick_8hz <= base_wrap;
      tick_4hz <= base_wrap && div_cnt[0];
      tick_2hz <= base_wrap && (div_cnt[1:0] == 2'b11);
      tick_1hz <= base_wrap && (div_cnt == 3'b111);
    end
  end

endmodule

// File: hdl/tone_generator.sv
`timescale 1ns/1ns

module tone_generator #(
  parameter int clk_hz = 50_000_000
) (
  input  logic                            CLK_50M,
  input  logic                            rst_n,
  input  logic                            sound_on,
  input  logic [organ_pkg::note_sel_w-1:0] note_sel,
  output logic [organ_pkg::sample_w-1:0]   audio_sample
);

  import organ_pkg::*;

  // Lowest note has the longest half-period
  localparam int cnt_w = $clog2(clk_hz / (2 * note_hz_table[0]) + 1);

  logic [cnt_w-1:0]      half_period [2**note_sel_w];
  logic [cnt_w-1:0]      half_cnt;
  logic [note_sel_w-1:0] note_q;
  logic                  wave;

  // Half-period table, fixed at elaboration
  for (genvar i = 0; i < 2**note_sel_w; i++)
  begin : g_half
    assign half_period[i] = cnt_w'(clk_hz / (2 * note_hz_table[i]));
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      note_q   <= '0;
      wave     <= 1'b0;
    end
    else
    begin
      note_q <= note_sel;
      if (!sound_on)
      begin
        half_cnt <= '0;
        wave     <= 1'b0;
      end
      else if (note_sel != note_q)
        half_cnt <= '0;
      else if (half_cnt >= half_period[note_sel] - 1'b1)
      begin
        half_cnt <= '0;
        wave     <= ~wave;
      end
      else
        half_cnt <= half_cnt + 1'b1;
    end
  end

  // Signed full scale, +127 high and -128 low
  assign audio_sample = (wave && sound_on) ? 8'h7F : 8'h80;

endmodule

// File: verif/organ_tb.sv
`timescale 1ns/1ns

module organ_tb;

  localparam int tb_clk_hz      = 100_000;
  localparam int default_count  = 12499;
  localparam int step_size      = 100;
  localparam int tone_off       = 500;
  localparam int note_hold      = 2000;
  localparam int note_tries     = 6;
  localparam int tap_len        = 2000;
  // Display latches twice per second
  localparam int refresh_period = tb_clk_hz / 2;
  // Three repeat periods plus 5000 cycles
  localparam int hold_len       = 3 * (tb_clk_hz / 10) + 5000;
  localparam int tone_cycles    = tone_off + note_tries * note_hold;
  localparam int led_cycles     = 9 * (tb_clk_hz / 8) + 9 * (tb_clk_hz / 4);
  localparam int cycle_limit    = (8 + tone_cycles + led_cycles + 100) * 3 / 2;

  // Note frequencies in Hz and active low segment codes, a in bit 0
  localparam int tone_hz [8] = '{523, 587, 659, 698, 783, 880, 987, 1046};
  localparam logic [6:0] seg_code [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        CLK_50M;
  logic        rst_n;
  logic [9:0]  sw;
  logic [3:0]  keys;
  logic [7:0]  led;
  logic [7:0]  audio_sample;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;

  integer      seed;
  int          note;
  int          model_count;
  int          cycle_count = 0;
  logic        check_reset;
  logic        check_disp;

  organ_top #(.clk_hz(tb_clk_hz)) UUT (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .sw          (sw),
    .keys        (keys),
    .led         (led),
    .audio_sample(audio_sample),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  function automatic int half_period_of(input logic [2:0] n);
    return tb_clk_hz / (2 * tone_hz[n]);
  endfunction

  function automatic logic [41:0] segs_of(input int value);
    logic [41:0] segs;
    logic [23:0] word;
    word = 24'(value & 32'hFFFF);
    for (int i = 0; i < 6; i++)
      segs[7*i +: 7] = seg_code[word[4*i +: 4]];
    return segs;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // ==================================================
  // Reference model and run-length counters
  // ==================================================
  logic        tone_edge, tone_check, led_moved, gap_check;
  logic [7:0]  audio_prev, led_prev, led_expect;
  logic [2:0]  note_prev, ref_pos, led_next;
  logic [1:0]  rate_prev;
  logic        ref_up;
  int          run_len, tone_toggles, led_gap, led_steps, half_expect, gap_expect;
  int          tone_checks, gap_checks, move_checks, disp_checks;
  logic [41:0] disp_segs, disp_expect;

  assign tone_edge   = audio_sample != audio_prev;
  assign tone_check  = tone_edge && sw[0] && sw[3:1] == note_prev && tone_toggles != 0;
  assign half_expect = half_period_of(sw[3:1]);
  assign led_moved   = led != led_prev;
  assign gap_check   = led_moved && sw[5:4] == rate_prev && led_steps != 0;
  assign gap_expect  = tb_clk_hz / (1 << rate_prev);
  assign led_next    = ref_up ? ref_pos + 3'd1 : ref_pos - 3'd1;
  assign led_expect  = 8'h01 << led_next;
  assign disp_segs   = {hex5, hex4, hex3, hex2, hex1, hex0};
  assign disp_expect = segs_of(model_count);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      audio_prev   <= 8'h80;
      note_prev    <= '0;
      run_len      <= 0;
      tone_toggles <= 0;
      led_prev     <= 8'h01;
      rate_prev    <= '0;
      ref_pos      <= '0;
      ref_up       <= 1'b1;
      led_gap      <= 0;
      led_steps    <= 0;
    end
    else
    begin
      audio_prev <= audio_sample;
      note_prev  <= sw[3:1];
      run_len    <= tone_edge ? 1 : run_len + 1;
      // Runs before the first toggle of a note are partial
      if (!sw[0] || sw[3:1] != note_prev)
        tone_toggles <= 0;
      else if (tone_edge)
        tone_toggles <= tone_toggles + 1;
      led_prev  <= led;
      rate_prev <= sw[5:4];
      led_gap   <= led_moved ? 1 : led_gap + 1;
      if (led_moved)
      begin
        ref_pos <= led_next;
        if (led_next == 3'd7)
          ref_up <= 1'b0;
        else if (led_next == 3'd0)
          ref_up <= 1'b1;
      end
      if (sw[5:4] != rate_prev)
        led_steps <= 0;
      else if (led_moved)
        led_steps <= led_steps + 1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tone_checks <= 0;
      gap_checks  <= 0;
      move_checks <= 0;
      disp_checks <= 0;
    end
    else
    begin
      tone_checks <= tone_checks + int'(tone_check);
      gap_checks  <= gap_checks + int'(gap_check);
      move_checks <= move_checks + int'(led_moved);
      disp_checks <= disp_checks + int'(check_disp);
    end
  end

  // ==================================================
  // Assertions
  // ==================================================
  a_reset_led: assert property (@(posedge CLK_50M) check_reset |-> led == 8'h01)
    else report_failure($sformatf("Mismatch led: got %h, expected %h", $sampled(led), 8'h01));

  a_reset_audio: assert property (@(posedge CLK_50M) check_reset |-> audio_sample == 8'h80)
    else report_failure($sformatf("Mismatch audio_sample: got %h, expected %h",
                                  $sampled(audio_sample), 8'h80));

  a_quiet: assert property (@(posedge CLK_50M) disable iff (!rst_n)
                            !sw[0] |-> audio_sample == 8'h80)
    else report_failure($sformatf("Mismatch audio_sample: got %h, expected %h",
                                  $sampled(audio_sample), 8'h80));

  a_half_period: assert property (@(posedge CLK_50M) disable iff (!rst_n)
                                  tone_check |-> run_len == half_expect)
    else report_failure($sformatf("Mismatch audio_sample run length: got %h, expected %h",
                                  $sampled(run_len), $sampled(half_expect)));

  a_led_move: assert property (@(posedge CLK_50M) disable iff (!rst_n)
                               led_moved |-> led == led_expect)
    else report_failure($sformatf("Mismatch led: got %h, expected %h",
                                  $sampled(led), $sampled(led_expect)));

  a_led_gap: assert property (@(posedge CLK_50M) disable iff (!rst_n)
                              gap_check |-> led_gap == gap_expect)
    else report_failure($sformatf("Mismatch led step interval: got %h, expected %h",
                                  $sampled(led_gap), $sampled(gap_expect)));

  a_display: assert property (@(posedge CLK_50M) check_disp |-> disp_segs == disp_expect)
    else report_failure($sformatf("Mismatch hex5..hex0: got %h, expected %h",
                                  $sampled(disp_segs), $sampled(disp_expect)));

  always @(posedge CLK_50M)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit)
      report_failure($sformatf("Timeout, run still busy after %0d cycles", cycle_limit));
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic step();
    @(posedge CLK_50M);
    #2;
  endtask

  task automatic tap_key(input int k, input int len);
    keys[k] = 1'b0;
    repeat (len) step();
    keys[k] = 1'b1;
  endtask

  // A full refresh period after the tap, so one refresh has latched the new count
  task automatic wait_display_refresh();
    repeat (refresh_period + 5) step();
    check_disp = 1'b1;
    step();
    check_disp = 1'b0;
  endtask

  task automatic wait_led_moves(input int n);
    logic [7:0] last;
    int         seen;
    seen = 0;
    last = led;
    while (seen < n)
    begin
      step();
      if (led != last)
      begin
        seen = seen + 1;
        last = led;
      end
    end
  endtask

  initial
  begin
    seed        = 68;
    sw          = '0;
    keys        = 4'hF;
    rst_n       = 1'b0;
    check_reset = 1'b0;
    check_disp  = 1'b0;
    model_count = default_count;
    repeat (8) @(posedge CLK_50M);
    #2;
    rst_n       = 1'b1;
    check_reset = 1'b1;
    check_disp  = 1'b1;
    step();
    check_reset = 1'b0;
    check_disp  = 1'b0;

    // Sound gated off, then six random notes
    repeat (tone_off) step();
    sw[0] = 1'b1;
    for (int i = 0; i < note_tries; i++)
    begin
      note    = $random(seed);
      sw[3:1] = note[2:0];
      repeat (note_hold) step();
    end
    sw[0] = 1'b0;

    fork
      begin
        sw[5:4] = 2'd3;
        wait_led_moves(9);
        sw[5:4] = 2'd2;
        wait_led_moves(9);
      end
      begin
        tap_key(0, tap_len);
        model_count = model_count + step_size;
        wait_display_refresh();
        tap_key(0, tap_len);
        model_count = model_count + step_size;
        wait_display_refresh();
        tap_key(1, tap_len);
        model_count = model_count - step_size;
        wait_display_refresh();
        // Press plus three repeats
        tap_key(0, hold_len);
        model_count = model_count + 4 * step_size;
        wait_display_refresh();
        tap_key(2, tap_len);
        model_count = default_count;
        wait_display_refresh();
      end
    join

    repeat (10) step();
    if (tone_checks > 0 && gap_checks > 0 && move_checks > 0 && disp_checks > 0)
    begin
      $display("TEST OK");
      $finish;
    end
    else
      report_failure("Some checks were never reached by the stimulus");
  end

endmodule

// File: vlog.f
hdl/organ_pkg.sv
hdl/tick_generator.sv
hdl/tone_generator.sv
hdl/led_chaser.sv
hdl/key_repeat.sv
hdl/speed_register.sv
hdl/hex_display.sv
hdl/organ_top.sv
verif/organ_tb.sv
